/* files.f */
logic/cab_pkg.sv
logic/config_loader.sv
logic/control_mapper.sv
logic/sigma_delta_dac.sv
logic/vector_dac.sv
logic/cabinet_io_top.sv
verification/cabinet_io_tb.sv

/* logic/cab_pkg.sv */
// Cabinet I/O shared types
package cab_pkg;

	// ====================
	// Download stream
	// ====================

	// Width of the download byte address
	localparam int DL_ADDR_W = 25;

	// Download index of the game-select byte
	localparam logic [7:0] IDX_GAME = 8'd1;

	// Download index of the DIP switch bank
	localparam logic [7:0] IDX_DIP = 8'd254;

	// Number of DIP switch bytes held
	localparam int DIP_COUNT = 8;

	// One write strobe from the download stream
	typedef struct packed {
		logic                 wr;
		logic [7:0]           index;
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
	} dl_write_t;

	// ====================
	// Game selection
	// ====================

	// Values of the game-select byte
	typedef enum logic [1:0] {
		game_bwidow   = 2'd0,
		game_gravitar = 2'd1,
		game_lunarbat = 2'd2,
		game_spacduel = 2'd3
	} game_e;

	// One-hot selection, all clear for an unknown game byte
	typedef struct packed {
		logic bwidow;
		logic gravitar;
		logic lunarbat;
		logic spacduel;
	} game_sel_t;

	// ====================
	// Control panel
	// ====================

	// Decoded cabinet controls, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_up;
		logic fire_down;
		logic fire_left;
		logic fire_right;
		logic start1;
		logic start2;
		logic coin;
	} panel_t;

	// Five input port bytes as seen by the game CPU
	typedef struct packed {
		logic [7:0] p0;
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] p3;
		logic [7:0] p4;
	} in_ports_t;

	// ====================
	// Vector output
	// ====================

	// Beam deflection and intensity from the game
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic [3:0] z;
	} vector_in_t;

	// Codes for the three 6-bit resistor ladders
	typedef struct packed {
		logic [5:0] x6;
		logic [5:0] y6;
		logic [5:0] z6;
	} ladder_t;

endpackage

/* logic/cabinet_io_top.sv */
// Cabinet I/O front end
module cabinet_io_top #(
	parameter int DAC_IN_W  = 10,
	parameter int DAC_OUT_W = 6,
	parameter int DIP_COUNT = 8
) (
	input  logic                clk_12,
	input  logic                rst,
	input  cab_pkg::dl_write_t  dl,
	input  logic [15:0]         joy0,
	input  logic [15:0]         joy1,
	input  cab_pkg::vector_in_t vec,
	output cab_pkg::in_ports_t  ports,
	output cab_pkg::ladder_t    ladder
);

	// Selection and DIP bytes from the loader
	cab_pkg::game_sel_t sel;
	logic [7:0]         dip0;
	logic [7:0]         dip1;
	logic [7:0]         dip2;

	// Input side
	config_loader #(
		.DIP_COUNT (DIP_COUNT)
	) u_config (
		.clk_12 (clk_12),
		.rst    (rst),
		.dl     (dl),
		.sel    (sel),
		.dip0   (dip0),
		.dip1   (dip1),
		.dip2   (dip2)
	);

	// Processing part, purely combinational
	control_mapper u_mapper (
		.joy0  (joy0),
		.joy1  (joy1),
		.sel   (sel),
		.dip0  (dip0),
		.dip1  (dip1),
		.dip2  (dip2),
		.ports (ports)
	);

	// Output side
	vector_dac #(
		.IN_W  (DAC_IN_W),
		.OUT_W (DAC_OUT_W)
	) u_vector (
		.clk_12 (clk_12),
		.rst    (rst),
		.vec    (vec),
		.ladder (ladder)
	);

endmodule

/* logic/config_loader.sv */
// Configuration loader
module config_loader #(
	parameter int DIP_COUNT = cab_pkg::DIP_COUNT
) (
	input  logic               clk_12,
	input  logic               rst,
	input  cab_pkg::dl_write_t dl,
	output cab_pkg::game_sel_t sel,
	output logic [7:0]         dip0,
	output logic [7:0]         dip1,
	output logic [7:0]         dip2
);

	// Bits needed to index the DIP bank
	localparam int DIP_IDX_W = (DIP_COUNT > 1) ? $clog2(DIP_COUNT) : 1;

	// Upper bound on accepted DIP addresses, at address width
	localparam bit [cab_pkg::DL_ADDR_W-1:0] DIP_LIMIT = DIP_COUNT[cab_pkg::DL_ADDR_W-1:0];

	logic [7:0]           game_byte;
	logic [7:0]           dip_bank [DIP_COUNT];
	logic                 game_wr;
	logic                 dip_wr;
	logic [DIP_IDX_W-1:0] dip_idx;

	// ====================
	// Write decode
	// ====================

	assign game_wr = dl.wr && (dl.index == cab_pkg::IDX_GAME);

	// Addresses past the bank are dropped
	assign dip_wr  = dl.wr && (dl.index == cab_pkg::IDX_DIP) && (dl.addr < DIP_LIMIT);
	assign dip_idx = dl.addr[DIP_IDX_W-1:0];

	// Raw game byte, cleared so the core comes up as Black Widow
	always_ff @(posedge clk_12) begin
		if (rst) begin
			game_byte <= '0;
		end else if (game_wr) begin
			game_byte <= dl.data;
		end
	end

	// DIP bank, one byte per address
	always_ff @(posedge clk_12) begin
		if (rst) begin
			for (int i = 0; i < DIP_COUNT; i++) begin
				dip_bank[i] <= '0;
			end
		end else if (dip_wr) begin
			dip_bank[dip_idx] <= dl.data;
		end
	end

	// Only the first three bytes reach the ports
	assign dip0 = dip_bank[0];
	assign dip1 = dip_bank[1];
	assign dip2 = dip_bank[2];

	// ====================
	// Game select
	// ====================

	// One-hot flags lag the byte by a cycle
	always_ff @(posedge clk_12) begin
		if (rst) begin
			sel <= '{bwidow: 1'b1, default: 1'b0};
		end else begin
			sel.bwidow   <= (game_byte == 8'(cab_pkg::game_bwidow));
			sel.gravitar <= (game_byte == 8'(cab_pkg::game_gravitar));
			sel.lunarbat <= (game_byte == 8'(cab_pkg::game_lunarbat));
			sel.spacduel <= (game_byte == 8'(cab_pkg::game_spacduel));
		end
	end

	// Never two games at once, else the port mux picks by priority
	a_sel_onehot0 : assert property (@(posedge clk_12) disable iff (rst) $onehot0(sel));

endmodule

/* logic/control_mapper.sv */
// Control-panel mapper
module control_mapper (
	input  logic [15:0]        joy0,
	input  logic [15:0]        joy1,
	input  cab_pkg::game_sel_t sel,
	input  logic [7:0]         dip0,
	input  logic [7:0]         dip1,
	input  logic [7:0]         dip2,
	output cab_pkg::in_ports_t ports
);

	cab_pkg::panel_t pnl;
	logic [7:0]      coin_port;

	// ====================
	// Joystick decode
	// ====================

	always_comb begin
		// Movement from the first stick only
		pnl.up    = joy0[3];
		pnl.down  = joy0[2];
		pnl.left  = joy0[1];
		pnl.right = joy0[0];

		// Fire from the face buttons or the second stick's directions
		pnl.fire_up    = joy0[6] | joy1[3];
		pnl.fire_down  = joy0[7] | joy1[2];
		pnl.fire_left  = joy0[5] | joy1[1];
		pnl.fire_right = joy0[4] | joy1[0];

		// Start and coin accepted from either stick
		pnl.start1 = joy0[8] | joy1[8];
		pnl.start2 = joy0[9] | joy1[9];
		pnl.coin   = joy0[10] | joy1[10];
	end

	// Coin port shared by the three mapped games
	// bit6 low keeps the 3 kHz line at rest, dip2 bits swapped into 5 and 4
	assign coin_port = {1'b1, 1'b0, ~dip2[0], ~dip2[1], 2'b11, ~pnl.coin, 1'b1};

	// ====================
	// Port build
	// ====================

	always_comb begin
		// Defaults, also used for Space Duel and unknown games
		ports.p0 = 8'hff;
		ports.p1 = dip0;
		ports.p2 = dip1;
		ports.p3 = 8'hff;
		ports.p4 = 8'hff;

		if (sel.bwidow) begin
			ports.p0 = coin_port;
			// Move stick in the low nibble
			ports.p3 = {4'hf, ~pnl.up, ~pnl.down, ~pnl.left, ~pnl.right};
			// Starts and fire stick
			ports.p4 = {1'b1, ~pnl.start2, ~pnl.start1, 1'b1,
				~pnl.fire_up, ~pnl.fire_down, ~pnl.fire_left, ~pnl.fire_right};
		end else if (sel.gravitar) begin
			ports.p0 = coin_port;
			// Rotate, thrust, fire and shield
			ports.p3 = {3'b111, ~pnl.fire_left, ~pnl.left, ~pnl.right,
				~pnl.fire_right, ~pnl.fire_down};
			ports.p4 = {1'b1, ~pnl.start2, ~pnl.start1, 5'b11111};
		end else if (sel.lunarbat) begin
			ports.p0 = coin_port;
			ports.p1 = 8'hff;
			ports.p2 = 8'hff;
			// true polarity on this board
			ports.p3 = {1'b0, pnl.start2, pnl.start1, pnl.fire_left,
				pnl.fire_down, pnl.fire_right, pnl.right, pnl.left};
			ports.p4 = 8'hff;
		end
	end

endmodule

/* logic/sigma_delta_dac.sv */
// First-order sigma-delta code reducer
module sigma_delta_dac #(
	parameter int IN_W  = 10,
	parameter int OUT_W = 6
) (
	input  logic             clk_12,
	input  logic             rst,
	input  logic [IN_W-1:0]  code_in,
	output logic [OUT_W-1:0] code_out
);

	// Bits below the ladder resolution
	localparam int FRAC_W = IN_W - OUT_W;

	logic [OUT_W-1:0]  coarse;
	logic [FRAC_W-1:0] frac;
	logic [FRAC_W-1:0] acc;
	logic [FRAC_W:0]   sum;
	logic              carry;

	// Coarse step and fraction of the wide code
	assign coarse = code_in[IN_W-1 -: OUT_W];
	assign frac   = code_in[FRAC_W-1:0];

	// Carry out of the residual adds one ladder step
	assign sum   = {1'b0, acc} + {1'b0, frac};
	assign carry = sum[FRAC_W];

	always_ff @(posedge clk_12) begin
		if (rst) begin
			acc      <= '0;
			code_out <= '0;
		end else begin
			// Remainder carries into the next cycle
			acc <= sum[FRAC_W-1:0];
			// Top code saturates instead of wrapping
			if (carry && (coarse != '1)) begin
				code_out <= coarse + 1'b1;
			end else begin
				code_out <= coarse;
			end
		end
	end

	// Output never strays more than one step above last cycle's coarse code
	a_near_coarse : assert property (@(posedge clk_12) disable iff (rst)
		!$past(rst) |->
			({1'b0, code_out} == {1'b0, $past(coarse)}) ||
			({1'b0, code_out} == {1'b0, $past(coarse)} + 1'b1));

endmodule

/* logic/vector_dac.sv */
// Vector ladder output stage
module vector_dac #(
	parameter int IN_W  = 10,
	parameter int OUT_W = 6
) (
	input  logic                clk_12,
	input  logic                rst,
	input  cab_pkg::vector_in_t vec,
	output cab_pkg::ladder_t    ladder
);

	logic [OUT_W-1:0] x_code;
	logic [OUT_W-1:0] y_code;
	logic [5:0]       z_drive;

	// ====================
	// Deflection channels
	// ====================

	// X goes out on the blue ladder
	sigma_delta_dac #(
		.IN_W  (IN_W),
		.OUT_W (OUT_W)
	) sd_x (
		.clk_12   (clk_12),
		.rst      (rst),
		.code_in  (vec.x),
		.code_out (x_code)
	);

	// Y goes out on the red ladder
	sigma_delta_dac #(
		.IN_W  (IN_W),
		.OUT_W (OUT_W)
	) sd_y (
		.clk_12   (clk_12),
		.rst      (rst),
		.code_in  (vec.y),
		.code_out (y_code)
	);

	// ====================
	// Beam drive
	// ====================

	// Scope takes a plain on/off level, zero intensity drives full scale
	always_ff @(posedge clk_12) begin
		if (rst) begin
			z_drive <= '0;
		end else begin
			z_drive <= (vec.z == '0) ? 6'h3f : 6'h00;
		end
	end

	// All three ladders share the one-cycle latency
	assign ladder = '{x6: x_code, y6: y_code, z6: z_drive};

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cabinet_io_tb -f files.f -o cabinet_io_sim
./obj_dir/cabinet_io_sim > sim.log 2>&1 || true
cat sim.log
if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* verification/cabinet_io_tb.sv */
// Cabinet I/O testbench
module cabinet_io_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Watchdog budget per trace step plus margin for reset and sweep
	localparam int CYCLES_PER_LINE = 24;
	localparam int CYCLE_MARGIN    = 200;
	localparam int SWEEP_PAIRS     = 64;

	logic                clk_12;
	logic                rst;
	cab_pkg::dl_write_t  dl;
	logic [15:0]         joy0;
	logic [15:0]         joy1;
	cab_pkg::vector_in_t vec;
	cab_pkg::in_ports_t  ports;
	cab_pkg::ladder_t    ladder;

	// Loader contents as written so far
	logic [7:0]  game_model;
	logic [7:0]  dip_model [8];
	string       trace_lines [$];
	int          cycle_limit = 0;
	int          cycle_count = 0;
	int          error_count = 0;
	logic [31:0] rng_state;

	cabinet_io_top dut0 (
		.clk_12 (clk_12),
		.rst    (rst),
		.dl     (dl),
		.joy0   (joy0),
		.joy1   (joy1),
		.vec    (vec),
		.ports  (ports),
		.ladder (ladder)
	);

	// 8 ns period
	initial begin
		clk_12 = 1'b0;
		forever #4 clk_12 = ~clk_12;
	end

	// ====================
	// Reporting and checks
	// ====================

	task automatic abort_run(input string why);
		error_count++;
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_ports(input string name, input cab_pkg::in_ports_t got,
		input cab_pkg::in_ports_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
			abort_run("Port bytes differ from the game's map");
		end
	endtask

	task automatic check_ladder_sum(input string name, input logic [9:0] got,
		input logic [9:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
			abort_run("Ladder codes do not average to the input code");
		end
	endtask

	// Beam drive only since the sums cover deflection
	task automatic check_beam(input string name, input cab_pkg::ladder_t got,
		input cab_pkg::ladder_t exp);
		if (got.z6 !== exp.z6) begin
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp.z6, got.z6);
			abort_run("Beam drive level is wrong");
		end
	endtask

	// ====================
	// Reference port map
	// ====================

	function automatic cab_pkg::in_ports_t expect_ports(input logic [15:0] j0,
		input logic [15:0] j1, input logic [7:0] game);
		cab_pkg::in_ports_t p;
		logic fu, fd, fl, fr;
		logic s1, s2, cn;
		fu = j0[6] | j1[3];
		fd = j0[7] | j1[2];
		fl = j0[5] | j1[1];
		fr = j0[4] | j1[0];
		s1 = j0[8] | j1[8];
		s2 = j0[9] | j1[9];
		cn = j0[10] | j1[10];
		p = {8'hff, dip_model[0], dip_model[1], 8'hff, 8'hff};
		// Coin port for the three mapped games
		if (game <= 8'd2) begin
			p.p0[6] = 1'b0;
			p.p0[5] = ~dip_model[2][0];
			p.p0[4] = ~dip_model[2][1];
			p.p0[1] = ~cn;
		end
		case (game)
			8'd0: begin
				p.p3[3:0] = ~j0[3:0];
				p.p4 = {1'b1, ~s2, ~s1, 1'b1, ~fu, ~fd, ~fl, ~fr};
			end
			8'd1: begin
				p.p3[4:0] = ~{fl, j0[1], j0[0], fr, fd};
				p.p4[6:5] = ~{s2, s1};
			end
			8'd2: begin
				p.p1 = 8'hff;
				p.p2 = 8'hff;
				p.p3 = {1'b0, s2, s1, fl, fd, fr, j0[0], j0[1]};
			end
			default: ;
		endcase
		return p;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// ====================
	// Stimulus
	// ====================

	// One-cycle strobe
	// Model follows the write rules
	task automatic dl_write(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_12);
		dl <= '{wr: 1'b1, index: idx, addr: addr, data: data};
		@(posedge clk_12);
		dl <= '0;
		if (idx == cab_pkg::IDX_GAME) game_model = data;
		if (idx == cab_pkg::IDX_DIP && addr < 25'd8) dip_model[addr[2:0]] = data;
	endtask

	task automatic apply_joy(input logic [15:0] j0, input logic [15:0] j1);
		@(posedge clk_12);
		joy0 <= j0;
		joy1 <= j1;
		@(negedge clk_12);
	endtask

	// Hold the code for 16 samples after the register edge
	task automatic vector_step(input cab_pkg::vector_in_t v, input logic [9:0] exp_x,
		input logic [9:0] exp_y, input logic [5:0] exp_z6);
		logic [9:0]       sum_x;
		logic [9:0]       sum_y;
		cab_pkg::ladder_t exp_beam;
		sum_x = '0;
		sum_y = '0;
		exp_beam = '{x6: 6'd0, y6: 6'd0, z6: exp_z6};
		@(posedge clk_12);
		vec <= v;
		// Register edge that takes in the new code
		@(posedge clk_12);
		repeat (16) begin
			@(negedge clk_12);
			sum_x = sum_x + {4'b0000, ladder.x6};
			sum_y = sum_y + {4'b0000, ladder.y6};
			check_beam("ladder.z6", ladder, exp_beam);
		end
		check_ladder_sum("ladder.x6 sum", sum_x, exp_x);
		check_ladder_sum("ladder.y6 sum", sum_y, exp_y);
	endtask

	// Keeps step lines and drops comments and blanks
	task automatic load_trace();
		int    fd;
		int    n;
		string line;
		fd = $fopen("verification/cabinet_trace.txt", "r");
		if (fd == 0) abort_run("Cannot open the trace file verification/cabinet_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") trace_lines.push_back(line);
		end
		$fclose(fd);
		if (trace_lines.size() == 0) abort_run("The trace file holds no steps");
	endtask

	task automatic run_step(input string line);
		logic [7:0]  idx, data, e0, e1, e2, e3, e4;
		logic [24:0] addr;
		logic [15:0] j0, j1;
		logic [9:0]  x, y, sx, sy;
		logic [3:0]  z;
		logic [5:0]  z6;
		int          n;
		case (line.getc(0))
			"W": begin
				n = $sscanf(line, "W %h %h %h", idx, addr, data);
				if (n != 3) abort_run({"Malformed write step: ", line});
				dl_write(idx, addr, data);
			end
			"J": begin
				n = $sscanf(line, "J %h %h %h %h %h %h %h", j0, j1, e0, e1, e2, e3, e4);
				if (n != 7) abort_run({"Malformed joystick step: ", line});
				apply_joy(j0, j1);
				check_ports("ports", ports, {e0, e1, e2, e3, e4});
			end
			"V": begin
				n = $sscanf(line, "V %h %h %h %h %h %h", x, y, z, sx, sy, z6);
				if (n != 6) abort_run({"Malformed vector step: ", line});
				vector_step('{x: x, y: y, z: z}, sx, sy, z6);
			end
			default: abort_run({"Unknown step kind in trace: ", line});
		endcase
	endtask

	// ====================
	// Watchdog and main
	// ====================

	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_12);
			cycle_count++;
		end
		abort_run($sformatf("Run did not finish in time, limit was %0d cycles", cycle_limit));
	end

	initial begin
		rst <= 1'b1;
		dl <= '0;
		joy0 <= '0;
		joy1 <= '0;
		vec <= '0;
		game_model = 8'd0;
		foreach (dip_model[i]) dip_model[i] = 8'd0;
		load_trace();
		cycle_limit = trace_lines.size() * CYCLES_PER_LINE + CYCLE_MARGIN;
		repeat (4) @(posedge clk_12);
		rst <= 1'b0;
		// Ladder still holds its reset value here
		@(negedge clk_12);
		check_ladder_sum("ladder.x6 after reset", {4'b0000, ladder.x6}, 10'd0);
		check_ladder_sum("ladder.y6 after reset", {4'b0000, ladder.y6}, 10'd0);
		check_beam("ladder.z6 after reset", ladder, '0);
		foreach (trace_lines[i]) run_step(trace_lines[i]);
		// Random pairs with a quarter per known game
		rng_state = 32'd30388;
		for (int g = 0; g < 4; g++) begin
			dl_write(cab_pkg::IDX_GAME, 25'd0, 8'(g));
			for (int i = 0; i < SWEEP_PAIRS / 4; i++) begin
				rng_state = xorshift(rng_state);
				apply_joy(rng_state[15:0], rng_state[31:16]);
				check_ports("ports in sweep", ports,
					expect_ports(rng_state[15:0], rng_state[31:16], game_model));
			end
		end
		if (error_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1, "Errors seen");
		end
	end

endmodule

/* verification/cabinet_trace.txt */
# W index addr data | J joy0 joy1 then expected p0 p1 p2 p3 p4
# V x y z then expected 16-cycle sums of x6 and y6 and z6, all hex
J 0000 0000 bf 00 00 ff ff
W fe 0 5a
W fe 1 c3
W fe 2 01
W fe 9 77
J 0000 0000 9f 5a c3 ff ff
J 000f 0000 9f 5a c3 f0 ff
J 00f0 0000 9f 5a c3 ff f0
J 0000 0005 9f 5a c3 ff fa
J 0000 0700 9d 5a c3 ff 9f
J 0108 0000 9f 5a c3 f7 df
W 01 0 01
J 0000 0000 9f 5a c3 ff ff
J 0023 0000 9f 5a c3 e3 ff
J 0000 0305 9f 5a c3 fc 9f
W 01 0 02
J 0000 0000 9f ff ff 00 ff
J 0003 0000 9f ff ff 03 ff
J 00b0 0000 9f ff ff 1c ff
J 0000 0700 9d ff ff 60 ff
W 01 0 03
J 0000 0000 ff 5a c3 ff ff
J 07ff 07ff ff 5a c3 ff ff
W 01 0 07
J 070f 0000 ff 5a c3 ff ff
W 01 0 00
W fe 2 02
J 0000 0000 af 5a c3 ff ff
V 000 000 0 000 000 3f
V 155 2aa 5 155 2aa 00
V 3ff 3f8 f 3f0 3f0 00
V 3f2 3ef 0 3f0 3ef 3f
V 001 00f 1 001 00f 00
V 200 17c 8 200 17c 00
